//--- src/vpu_lane.sv
`timescale 1ns/1ps

module vpu_lane (
    input  logic                                 clk,
    input  logic                                 rst_n,

    // Slice interface from the source port
    input  logic                                 operand_valid_i,
    input  logic                                 operand_last_i,
    input  logic [vpu_pkg::DWIDTH_PER_EXEC-1:0]  operand_data_i [vpu_pkg::SRAM_R_PORT_CNT],
    input  logic                                 src_done_i,
    output logic                                 operand_rden_o,

    // Result stream
    output logic [vpu_pkg::DWIDTH_PER_EXEC-1:0]  res_data_o,
    output logic                                 res_valid_o,
    input  logic                                 res_ready_i,
    output logic                                 done_o
);
    import vpu_pkg::*;

    // Elements per slice
    localparam int LANES = DWIDTH_PER_EXEC / ELEM_WIDTH;

    logic                        stall;
    logic                        s1_valid_q;
    logic [2*ELEM_WIDTH-1:0]     s1_prod_q   [LANES];
    logic [DWIDTH_PER_EXEC-1:0]  s1_addend_q;
    logic [DWIDTH_PER_EXEC-1:0]  sum;
    logic                        op_open_q;

    // Output held while the sink is not ready
    assign stall = res_valid_o && !res_ready_i;

    // Take a slice only when stage one can move
    assign operand_rden_o = operand_valid_i && !stall;

    // Stage one, products plus the port 2 addend
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid_q <= 1'b0;
        end else if (!stall) begin
            s1_valid_q <= operand_rden_o;
        end
    end

    always_ff @(posedge clk) begin
        if (operand_rden_o) begin
            for (int e = 0; e < LANES; e++) begin
                s1_prod_q[e] <= operand_data_i[0][e*ELEM_WIDTH +: ELEM_WIDTH] *
                                operand_data_i[1][e*ELEM_WIDTH +: ELEM_WIDTH];
            end
            s1_addend_q <= operand_data_i[2];
        end
    end

    // Add per element, wrap to element width
    always_comb begin
        for (int e = 0; e < LANES; e++) begin
            sum[e*ELEM_WIDTH +: ELEM_WIDTH] = s1_prod_q[e][ELEM_WIDTH-1:0] +
                                              s1_addend_q[e*ELEM_WIDTH +: ELEM_WIDTH];
        end
    end

    // Stage two, result register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid_o <= 1'b0;
        end else if (!stall) begin
            res_valid_o <= s1_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && s1_valid_q) begin
            res_data_o <= sum;
        end
    end

    // Open between the first and the last slice of one operation
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_open_q <= 1'b0;
        end else if (operand_rden_o) begin
            op_open_q <= !operand_last_i;
        end
    end

    // Idle with the source done and the pipeline drained
    assign done_o = src_done_i && !op_open_q && !s1_valid_q && !res_valid_o;

endmodule

//--- src/vpu_pkg.sv
package vpu_pkg;

    // Source port count, one SRAM bank per port
    localparam int SRAM_R_PORT_CNT = 3;

    // One SRAM word as returned on the Wishbone data bus
    localparam int SRAM_DATA_WIDTH = 64;

    // Slice handed to the lane per rden
    localparam int DWIDTH_PER_EXEC = 32;

    // Slices per SRAM word
    localparam int EXEC_CNT = SRAM_DATA_WIDTH / DWIDTH_PER_EXEC;

    // Width of the slice counter
    localparam int EXEC_CNT_LG2 = 1;

    // One vector element inside a slice
    localparam int ELEM_WIDTH = 16;

endpackage

//--- src/vpu_src_port.sv
`timescale 1ns/1ps

module vpu_src_port #(
    parameter int ADDR_W = 10
) (
    input  logic                                 clk,
    input  logic                                 rst_n,

    // Operation setup, sampled with start
    input  logic                                 start_i,
    input  logic [vpu_pkg::SRAM_R_PORT_CNT-1:0]  rd_en_i,
    input  logic [ADDR_W-1:0]                    addr0_i,
    input  logic [ADDR_W-1:0]                    addr1_i,
    input  logic [ADDR_W-1:0]                    addr2_i,

    // Slice interface toward the lane
    input  logic                                 operand_rden_i,
    output logic                                 operand_valid_o,
    output logic                                 operand_last_o,
    output logic [vpu_pkg::DWIDTH_PER_EXEC-1:0]  operand_data_o [vpu_pkg::SRAM_R_PORT_CNT],
    output logic                                 src_done_o,

    // Wishbone masters, one per bank
    output logic                                 wb0_cyc_o,
    output logic                                 wb0_stb_o,
    output logic [ADDR_W-1:0]                    wb0_adr_o,
    input  logic [vpu_pkg::SRAM_DATA_WIDTH-1:0]  wb0_dat_i,
    input  logic                                 wb0_ack_i,
    output logic                                 wb1_cyc_o,
    output logic                                 wb1_stb_o,
    output logic [ADDR_W-1:0]                    wb1_adr_o,
    input  logic [vpu_pkg::SRAM_DATA_WIDTH-1:0]  wb1_dat_i,
    input  logic                                 wb1_ack_i,
    output logic                                 wb2_cyc_o,
    output logic                                 wb2_stb_o,
    output logic [ADDR_W-1:0]                    wb2_adr_o,
    input  logic [vpu_pkg::SRAM_DATA_WIDTH-1:0]  wb2_dat_i,
    input  logic                                 wb2_ack_i
);
    import vpu_pkg::*;

    logic [SRAM_R_PORT_CNT-1:0]  ctrl_done;
    logic [SRAM_R_PORT_CNT-1:0]  wren;
    logic [SRAM_DATA_WIDTH-1:0]  wdata     [SRAM_R_PORT_CNT];
    logic [ADDR_W-1:0]           raddr     [SRAM_R_PORT_CNT];
    logic                        wb_cyc    [SRAM_R_PORT_CNT];
    logic                        wb_stb    [SRAM_R_PORT_CNT];
    logic [ADDR_W-1:0]           wb_adr    [SRAM_R_PORT_CNT];
    logic [SRAM_DATA_WIDTH-1:0]  wb_dat    [SRAM_R_PORT_CNT];
    logic                        wb_ack    [SRAM_R_PORT_CNT];

    // Operand buffers, one SRAM word per port
    logic [SRAM_DATA_WIDTH-1:0]  operand_q [SRAM_R_PORT_CNT];
    logic [SRAM_R_PORT_CNT-1:0]  loaded_q;
    logic                        armed_q;
    logic                        valid_q;
    logic [EXEC_CNT_LG2-1:0]     cnt_q;
    logic                        start_acc;
    logic                        last_slice;

    // Only an idle port takes a new start
    assign start_acc = start_i && src_done_o;

    assign raddr[0]  = addr0_i;
    assign raddr[1]  = addr1_i;
    assign raddr[2]  = addr2_i;
    assign wb_dat[0] = wb0_dat_i;
    assign wb_dat[1] = wb1_dat_i;
    assign wb_dat[2] = wb2_dat_i;
    assign wb_ack[0] = wb0_ack_i;
    assign wb_ack[1] = wb1_ack_i;
    assign wb_ack[2] = wb2_ack_i;

    genvar p;
    generate
        for (p = 0; p < SRAM_R_PORT_CNT; p++) begin : g_port
            vpu_src_port_ctrl #(
                .ADDR_W   (ADDR_W)
            ) ctrl_i (
                .clk      (clk),
                .rst_n    (rst_n),
                .start_i  (start_acc),
                .rd_en_i  (rd_en_i[p]),
                .raddr_i  (raddr[p]),
                .done_o   (ctrl_done[p]),
                .wdata_o  (wdata[p]),
                .wren_o   (wren[p]),
                .wb_cyc_o (wb_cyc[p]),
                .wb_stb_o (wb_stb[p]),
                .wb_adr_o (wb_adr[p]),
                .wb_dat_i (wb_dat[p]),
                .wb_ack_i (wb_ack[p])
            );

            // Payload register, no reset
            always_ff @(posedge clk) begin
                if (wren[p]) begin
                    operand_q[p] <= wdata[p];
                end
            end

            // Current slice out of the held word
            assign operand_data_o[p] = operand_q[p][cnt_q*DWIDTH_PER_EXEC +: DWIDTH_PER_EXEC];
        end
    endgenerate

    assign wb0_cyc_o = wb_cyc[0];
    assign wb0_stb_o = wb_stb[0];
    assign wb0_adr_o = wb_adr[0];
    assign wb1_cyc_o = wb_cyc[1];
    assign wb1_stb_o = wb_stb[1];
    assign wb1_adr_o = wb_adr[1];
    assign wb2_cyc_o = wb_cyc[2];
    assign wb2_stb_o = wb_stb[2];
    assign wb2_adr_o = wb_adr[2];

    assign last_slice = (cnt_q == EXEC_CNT_LG2'(EXEC_CNT - 1));

    // Loaded flags, armed until all ports have written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            loaded_q <= '0;
            armed_q  <= 1'b0;
            valid_q  <= 1'b0;
            cnt_q    <= '0;
        end else begin
            if (start_acc) begin
                loaded_q <= '0;
                armed_q  <= 1'b1;
            end else begin
                loaded_q <= loaded_q | wren;
                // Valid the cycle after the last write lands
                if (armed_q && &(loaded_q | wren)) begin
                    armed_q <= 1'b0;
                    valid_q <= 1'b1;
                end
            end
            if (valid_q && operand_rden_i) begin
                // Wrap after the last slice and empty the buffer
                if (last_slice) begin
                    cnt_q   <= '0;
                    valid_q <= 1'b0;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    assign operand_valid_o = valid_q;
    assign operand_last_o  = valid_q && last_slice;

    // Idle once every fetch is done and nothing waits in the buffer
    assign src_done_o = (&ctrl_done) && !armed_q && !valid_q;

endmodule

//--- src/vpu_src_port_ctrl.sv
`timescale 1ns/1ps

module vpu_src_port_ctrl #(
    parameter int ADDR_W = 10
) (
    input  logic                                 clk,
    input  logic                                 rst_n,

    // Start and per-port setup
    input  logic                                 start_i,
    input  logic                                 rd_en_i,
    input  logic [ADDR_W-1:0]                    raddr_i,
    output logic                                 done_o,

    // Write side toward the operand buffer
    output logic [vpu_pkg::SRAM_DATA_WIDTH-1:0]  wdata_o,
    output logic                                 wren_o,

    // Wishbone classic read master
    output logic                                 wb_cyc_o,
    output logic                                 wb_stb_o,
    output logic [ADDR_W-1:0]                    wb_adr_o,
    input  logic [vpu_pkg::SRAM_DATA_WIDTH-1:0]  wb_dat_i,
    input  logic                                 wb_ack_i
);
    import vpu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_zero
    } ctrl_state_e;

    ctrl_state_e        state_q;
    ctrl_state_e        state_d;

    // Word address latched with start
    logic [ADDR_W-1:0]  adr_q;

    // Next-state logic
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                // Disabled port skips the bus and fills zero
                if (start_i) begin
                    state_d = rd_en_i ? st_req : st_zero;
                end
            end
            st_req: begin
                // Single beat, back to idle after the ack
                if (wb_ack_i) begin
                    state_d = st_idle;
                end
            end
            st_zero: begin
                state_d = st_idle;
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // Address held for the whole request
    always_ff @(posedge clk) begin
        if (state_q == st_idle && start_i) begin
            adr_q <= raddr_i;
        end
    end

    // cyc and stb move together, dropped the cycle after ack
    assign wb_cyc_o = (state_q == st_req);
    assign wb_stb_o = (state_q == st_req);
    assign wb_adr_o = adr_q;

    // Ack cycle carries the read data straight into the buffer
    assign wren_o  = (state_q == st_req && wb_ack_i) || (state_q == st_zero);
    assign wdata_o = (state_q == st_req) ? wb_dat_i : {SRAM_DATA_WIDTH{1'b0}};

    // Idle means ready for the next start
    assign done_o = (state_q == st_idle);

endmodule

//--- src/vpu_src_top.sv
`timescale 1ns/1ps

module vpu_src_top #(
    parameter int ADDR_W = 10
) (
    input  logic                                 clk,
    input  logic                                 rst_n,

    // Operation request
    input  logic                                 start_i,
    input  logic [vpu_pkg::SRAM_R_PORT_CNT-1:0]  rd_en_i,
    input  logic [ADDR_W-1:0]                    addr0_i,
    input  logic [ADDR_W-1:0]                    addr1_i,
    input  logic [ADDR_W-1:0]                    addr2_i,
    output logic                                 done_o,

    // Bank 0
    output logic                                 wb0_cyc_o,
    output logic                                 wb0_stb_o,
    output logic [ADDR_W-1:0]                    wb0_adr_o,
    input  logic [vpu_pkg::SRAM_DATA_WIDTH-1:0]  wb0_dat_i,
    input  logic                                 wb0_ack_i,

    // Bank 1
    output logic                                 wb1_cyc_o,
    output logic                                 wb1_stb_o,
    output logic [ADDR_W-1:0]                    wb1_adr_o,
    input  logic [vpu_pkg::SRAM_DATA_WIDTH-1:0]  wb1_dat_i,
    input  logic                                 wb1_ack_i,

    // Bank 2
    output logic                                 wb2_cyc_o,
    output logic                                 wb2_stb_o,
    output logic [ADDR_W-1:0]                    wb2_adr_o,
    input  logic [vpu_pkg::SRAM_DATA_WIDTH-1:0]  wb2_dat_i,
    input  logic                                 wb2_ack_i,

    // Result stream
    output logic [vpu_pkg::DWIDTH_PER_EXEC-1:0]  res_data_o,
    output logic                                 res_valid_o,
    input  logic                                 res_ready_i
);
    import vpu_pkg::*;

    logic                        start_acc;
    logic                        operand_valid;
    logic                        operand_last;
    logic                        operand_rden;
    logic [DWIDTH_PER_EXEC-1:0]  operand_data [SRAM_R_PORT_CNT];
    logic                        src_done;

    // Start dropped while the lane still drains
    assign start_acc = start_i && done_o;

    vpu_src_port #(
        .ADDR_W          (ADDR_W)
    ) src_port_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_i         (start_acc),
        .rd_en_i         (rd_en_i),
        .addr0_i         (addr0_i),
        .addr1_i         (addr1_i),
        .addr2_i         (addr2_i),
        .operand_rden_i  (operand_rden),
        .operand_valid_o (operand_valid),
        .operand_last_o  (operand_last),
        .operand_data_o  (operand_data),
        .src_done_o      (src_done),
        .wb0_cyc_o       (wb0_cyc_o),
        .wb0_stb_o       (wb0_stb_o),
        .wb0_adr_o       (wb0_adr_o),
        .wb0_dat_i       (wb0_dat_i),
        .wb0_ack_i       (wb0_ack_i),
        .wb1_cyc_o       (wb1_cyc_o),
        .wb1_stb_o       (wb1_stb_o),
        .wb1_adr_o       (wb1_adr_o),
        .wb1_dat_i       (wb1_dat_i),
        .wb1_ack_i       (wb1_ack_i),
        .wb2_cyc_o       (wb2_cyc_o),
        .wb2_stb_o       (wb2_stb_o),
        .wb2_adr_o       (wb2_adr_o),
        .wb2_dat_i       (wb2_dat_i),
        .wb2_ack_i       (wb2_ack_i)
    );

    vpu_lane lane_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .operand_valid_i (operand_valid),
        .operand_last_i  (operand_last),
        .operand_data_i  (operand_data),
        .src_done_i      (src_done),
        .operand_rden_o  (operand_rden),
        .res_data_o      (res_data_o),
        .res_valid_o     (res_valid_o),
        .res_ready_i     (res_ready_i),
        .done_o          (done_o)
    );

endmodule

//--- tests/tb_vpu_src.sv
`timescale 1ns/1ps

module tb_vpu_src;
    import vpu_pkg::*;

    localparam int ADDR_W     = 10;
    localparam int BANK_WORDS = 1024;
    // Six tests, at most 40 operations of about 60 cycles, plus margin
    localparam int CYCLE_LIMIT = 4000;

    logic                        clk;
    logic                        rst_n;
    logic                        start_i;
    logic [SRAM_R_PORT_CNT-1:0]  rd_en_i;
    logic [ADDR_W-1:0]           addr0_i;
    logic [ADDR_W-1:0]           addr1_i;
    logic [ADDR_W-1:0]           addr2_i;
    logic                        done_o;
    logic [DWIDTH_PER_EXEC-1:0]  res_data_o;
    logic                        res_valid_o;
    logic                        res_ready_i;

    // Bus signals indexed by bank
    wire  [SRAM_R_PORT_CNT-1:0]  wb_cyc;
    wire  [SRAM_R_PORT_CNT-1:0]  wb_stb;
    wire  [ADDR_W-1:0]           wb_adr [SRAM_R_PORT_CNT];
    logic [SRAM_R_PORT_CNT-1:0]  wb_ack;
    logic [SRAM_DATA_WIDTH-1:0]  wb_dat [SRAM_R_PORT_CNT];

    // SRAM bank contents and ack timing
    logic [SRAM_DATA_WIDTH-1:0]  bank_mem [SRAM_R_PORT_CNT][BANK_WORDS];
    int                          wait_cnt [SRAM_R_PORT_CNT];
    int                          ack_delay [SRAM_R_PORT_CNT];
    logic [SRAM_R_PORT_CNT-1:0]  cyc_seen;
    logic                        rand_delay;
    logic                        rand_ready;

    // Scoreboard
    logic [DWIDTH_PER_EXEC-1:0]  exp_q[$];
    logic [DWIDTH_PER_EXEC-1:0]  got_q[$];
    int                          err_cnt;
    int                          tests_run;
    int                          tests_failed;
    int                          cycle_cnt;
    int                          total_errs;

    vpu_src_top #(
        .ADDR_W      (ADDR_W)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .rd_en_i     (rd_en_i),
        .addr0_i     (addr0_i),
        .addr1_i     (addr1_i),
        .addr2_i     (addr2_i),
        .done_o      (done_o),
        .wb0_cyc_o   (wb_cyc[0]),
        .wb0_stb_o   (wb_stb[0]),
        .wb0_adr_o   (wb_adr[0]),
        .wb0_dat_i   (wb_dat[0]),
        .wb0_ack_i   (wb_ack[0]),
        .wb1_cyc_o   (wb_cyc[1]),
        .wb1_stb_o   (wb_stb[1]),
        .wb1_adr_o   (wb_adr[1]),
        .wb1_dat_i   (wb_dat[1]),
        .wb1_ack_i   (wb_ack[1]),
        .wb2_cyc_o   (wb_cyc[2]),
        .wb2_stb_o   (wb_stb[2]),
        .wb2_adr_o   (wb_adr[2]),
        .wb2_dat_i   (wb_dat[2]),
        .wb2_ack_i   (wb_ack[2]),
        .res_data_o  (res_data_o),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i)
    );

    bind vpu_src_top vpu_src_checker #(.ADDR_W(ADDR_W)) checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Bank models and sink ready, all driven on the falling edge
    always @(negedge clk) begin
        for (int b = 0; b < SRAM_R_PORT_CNT; b++) begin
            if (wb_cyc[b]) begin
                cyc_seen[b] = 1'b1;
            end
            if (wb_ack[b]) begin
                // One beat only, fresh delay for the next request
                wb_ack[b]    = 1'b0;
                wait_cnt[b]  = 0;
                ack_delay[b] = rand_delay ? $urandom_range(7, 0) : 0;
            end else if (wb_stb[b]) begin
                if (wait_cnt[b] == ack_delay[b]) begin
                    wb_ack[b] = 1'b1;
                    wb_dat[b] = bank_mem[b][wb_adr[b]];
                end else begin
                    wait_cnt[b]++;
                end
            end
        end
        res_ready_i = rand_ready ? 1'($urandom_range(1, 0)) : 1'b1;
    end

    // Every accepted result word
    always @(posedge clk) begin
        if (rst_n && res_valid_o && res_ready_i) begin
            got_q.push_back(res_data_o);
        end
    end

    // Per element a*b + c, wrapped to 16 bits
    function automatic logic [DWIDTH_PER_EXEC-1:0] expect_word(
        input logic [DWIDTH_PER_EXEC-1:0] a,
        input logic [DWIDTH_PER_EXEC-1:0] b,
        input logic [DWIDTH_PER_EXEC-1:0] c
    );
        logic [DWIDTH_PER_EXEC-1:0] r;
        logic [31:0]                prod;
        for (int e = 0; e < DWIDTH_PER_EXEC / 16; e++) begin
            prod          = a[e*16 +: 16] * b[e*16 +: 16];
            r[e*16 +: 16] = prod[15:0] + c[e*16 +: 16];
        end
        return r;
    endfunction

    task automatic pulse_start(input logic [2:0] en, input int a0, input int a1, input int a2);
        @(negedge clk);
        rd_en_i = en;
        addr0_i = ADDR_W'(a0);
        addr1_i = ADDR_W'(a1);
        addr2_i = ADDR_W'(a2);
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
    endtask

    task automatic wait_idle();
        while (!done_o) begin
            @(negedge clk);
        end
    endtask

    // Both slices from the bank contents, low slice first
    task automatic queue_expected(input logic [2:0] en, input int a0, input int a1,
                                  input int a2);
        logic [SRAM_DATA_WIDTH-1:0] w [SRAM_R_PORT_CNT];
        w[0] = en[0] ? bank_mem[0][a0] : '0;
        w[1] = en[1] ? bank_mem[1][a1] : '0;
        w[2] = en[2] ? bank_mem[2][a2] : '0;
        exp_q.push_back(expect_word(w[0][31:0], w[1][31:0], w[2][31:0]));
        exp_q.push_back(expect_word(w[0][63:32], w[1][63:32], w[2][63:32]));
    endtask

    // Queue both slices, then run the operation
    task automatic run_op(input logic [2:0] en, input int a0, input int a1, input int a2);
        queue_expected(en, a0, a1, a2);
        pulse_start(en, a0, a1, a2);
        wait_idle();
    endtask

    task automatic compare_results(input string name);
        if (got_q.size() != exp_q.size()) begin
            $display("Error %s result count: expected %0d, actual %0d",
                     name, exp_q.size(), got_q.size());
            err_cnt++;
        end else begin
            for (int i = 0; i < exp_q.size(); i++) begin
                if (got_q[i] != exp_q[i]) begin
                    $display("Error %s word %0d: expected %h, actual %h",
                             name, i, exp_q[i], got_q[i]);
                    err_cnt++;
                end
            end
        end
        exp_q.delete();
        got_q.delete();
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        tests_run++;
        if (err_cnt == errs_at_start) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, err_cnt - errs_at_start);
        end
    endtask

    task automatic reset_values();
        int e0;
        e0 = err_cnt;
        if (done_o !== 1'b1) begin
            $display("Error reset_values done_o: expected 1, actual %b", done_o);
            err_cnt++;
        end
        if (res_valid_o !== 1'b0) begin
            $display("Error reset_values res_valid_o: expected 0, actual %b", res_valid_o);
            err_cnt++;
        end
        if (wb_cyc !== 3'b000) begin
            $display("Error reset_values cyc: expected 000, actual %b", wb_cyc);
            err_cnt++;
        end
        report_test("reset_values", e0);
    endtask

    task automatic single_op();
        int e0;
        e0 = err_cnt;
        queue_expected(3'b111, 5, 17, 1000);
        pulse_start(3'b111, 5, 17, 1000);
        // Busy from the cycle after the start
        if (done_o !== 1'b0) begin
            $display("Error single_op done_o: expected 0, actual %b", done_o);
            err_cnt++;
        end
        // Both words must be in before done rises again
        wait_idle();
        compare_results("single_op");
        report_test("single_op", e0);
    endtask

    task automatic disabled_ports();
        int e0;
        e0 = err_cnt;
        // Port 2 off gives plain products
        cyc_seen = '0;
        run_op(3'b011, 40, 41, 42);
        if (cyc_seen[2]) begin
            $display("disabled_ports: bank 2 saw a bus cycle while its port was off");
            err_cnt++;
        end
        // Port 0 off leaves only the addend
        cyc_seen = '0;
        run_op(3'b110, 43, 44, 45);
        if (cyc_seen[0]) begin
            $display("disabled_ports: bank 0 saw a bus cycle while its port was off");
            err_cnt++;
        end
        compare_results("disabled_ports");
        report_test("disabled_ports", e0);
    endtask

    task automatic random_ack_delays();
        int e0;
        e0 = err_cnt;
        rand_delay = 1'b1;
        repeat (20) begin
            run_op(3'b111, $urandom_range(1023, 0), $urandom_range(1023, 0),
                   $urandom_range(1023, 0));
        end
        compare_results("random_ack_delays");
        report_test("random_ack_delays", e0);
    endtask

    task automatic output_backpressure();
        int e0;
        e0 = err_cnt;
        rand_ready = 1'b1;
        repeat (10) begin
            run_op(3'b111, $urandom_range(1023, 0), $urandom_range(1023, 0),
                   $urandom_range(1023, 0));
        end
        rand_ready = 1'b0;
        compare_results("output_backpressure");
        report_test("output_backpressure", e0);
    endtask

    task automatic start_while_busy();
        logic [SRAM_DATA_WIDTH-1:0] w [SRAM_R_PORT_CNT];
        int                         e0;
        e0 = err_cnt;
        for (int p = 0; p < SRAM_R_PORT_CNT; p++) begin
            w[p] = bank_mem[p][100 + p];
        end
        exp_q.push_back(expect_word(w[0][31:0], w[1][31:0], w[2][31:0]));
        exp_q.push_back(expect_word(w[0][63:32], w[1][63:32], w[2][63:32]));
        pulse_start(3'b111, 100, 101, 102);
        if (done_o !== 1'b0) begin
            $display("start_while_busy: unit was idle right after its start");
            err_cnt++;
        end
        // Second request lands mid-operation and must vanish
        pulse_start(3'b111, 200, 201, 202);
        wait_idle();
        repeat (10) @(negedge clk);
        compare_results("start_while_busy");
        report_test("start_while_busy", e0);
    endtask

    initial begin
        void'($urandom(32'hbd1b_35ba));
        rst_n       = 1'b0;
        start_i     = 1'b0;
        rd_en_i     = '0;
        addr0_i     = '0;
        addr1_i     = '0;
        addr2_i     = '0;
        res_ready_i = 1'b1;
        wb_ack      = '0;
        cyc_seen    = '0;
        rand_delay  = 1'b0;
        rand_ready  = 1'b0;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycle_cnt    = 0;
        for (int b = 0; b < SRAM_R_PORT_CNT; b++) begin
            wb_dat[b]    = '0;
            wait_cnt[b]  = 0;
            ack_delay[b] = 0;
            // Random words with the address folded in
            for (int a = 0; a < BANK_WORDS; a++) begin
                bank_mem[b][a] = {$urandom(), $urandom() ^ 32'(a * 3 + b)};
            end
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        reset_values();
        single_op();
        disabled_ports();
        random_ack_delays();
        output_backpressure();
        start_while_busy();

        total_errs = err_cnt + dut_i.checker_i.fail_cnt;
        $display("Summary: %0d tests run, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, err_cnt, dut_i.checker_i.fail_cnt);
        if (total_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tests/vpu_src_checker.sv
`timescale 1ns/1ps

module vpu_src_checker #(
    parameter int ADDR_W = 10
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 wb0_cyc_o,
    input  logic                                 wb0_stb_o,
    input  logic [ADDR_W-1:0]                    wb0_adr_o,
    input  logic                                 wb0_ack_i,
    input  logic                                 wb1_cyc_o,
    input  logic                                 wb1_stb_o,
    input  logic [ADDR_W-1:0]                    wb1_adr_o,
    input  logic                                 wb1_ack_i,
    input  logic                                 wb2_cyc_o,
    input  logic                                 wb2_stb_o,
    input  logic [ADDR_W-1:0]                    wb2_adr_o,
    input  logic                                 wb2_ack_i,
    input  logic [vpu_pkg::DWIDTH_PER_EXEC-1:0]  res_data_o,
    input  logic                                 res_valid_o,
    input  logic                                 res_ready_i,
    input  logic                                 done_o
);
    // Failed assertions, read back by the testbench
    int fail_cnt = 0;

    // No strobe outside a cycle on any bank
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        !((wb0_stb_o && !wb0_cyc_o) || (wb1_stb_o && !wb1_cyc_o) || (wb2_stb_o && !wb2_cyc_o)))
        else begin fail_cnt++; $error("Wishbone stb high without cyc"); end

    // Address frozen until the bank acks
    a_adr0_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (wb0_stb_o && !wb0_ack_i) |=> $stable(wb0_adr_o))
        else begin fail_cnt++; $error("Bank 0 address moved before ack"); end
    a_adr1_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (wb1_stb_o && !wb1_ack_i) |=> $stable(wb1_adr_o))
        else begin fail_cnt++; $error("Bank 1 address moved before ack"); end
    a_adr2_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (wb2_stb_o && !wb2_ack_i) |=> $stable(wb2_adr_o))
        else begin fail_cnt++; $error("Bank 2 address moved before ack"); end

    // Result held under back-pressure
    a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_data_o)))
        else begin fail_cnt++; $error("Result changed while the sink stalled"); end

    // Idle unit keeps every bus quiet
    a_done_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> !(wb0_cyc_o || wb1_cyc_o || wb2_cyc_o))
        else begin fail_cnt++; $error("Bus cycle open while the unit reports idle"); end

endmodule

//--- vpu_fetch.f
src/vpu_pkg.sv
src/vpu_src_port_ctrl.sv
src/vpu_src_port.sv
src/vpu_lane.sv
src/vpu_src_top.sv
tests/vpu_src_checker.sv
tests/tb_vpu_src.sv
